//--- all.f
logic/lane_adder_pkg.sv
logic/axis_beat_if.sv
logic/lane_add_pipe.sv
logic/axis_sync_fifo.sv
logic/stream_adder_top.sv
tests/tb_stream_adder.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the stream adder testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_stream_adder -f all.f -o sim_stream_adder
./obj_dir/sim_stream_adder | tee sim.log
if grep -q "Finished with no errors" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

//--- tests/tb_stream_adder.sv
/*
  Testbench for the stream lane adder
  Random beats from a fixed seed checked against a queue model
  Phases for lane arithmetic, sidebands, constant changes and back-pressure
*/
`timescale 1ns/1ns

module tb_stream_adder;
  import lane_adder_pkg::*;

  localparam int wait_limit = 2000; // Cycles any single wait may take

  logic                s_axis_aclk;
  logic                rst;
  lane_t               ctrl_constant;
  logic                s_axis_tvalid;
  logic                s_axis_tready;
  axis_data_t          s_axis_tdata;
  logic [data_w/8-1:0] s_axis_tkeep;
  logic                s_axis_tlast;
  logic [id_w-1:0]     s_axis_tid;
  logic [user_w-1:0]   s_axis_tuser;
  logic                m_axis_tvalid;
  logic                m_axis_tready;
  axis_data_t          m_axis_tdata;
  logic [data_w/8-1:0] m_axis_tkeep;
  logic                m_axis_tlast;
  logic [id_w-1:0]     m_axis_tid;
  logic [user_w-1:0]   m_axis_tuser;

  beat_meta_t in_meta;
  beat_meta_t out_meta;

  // Reference model, one entry per accepted beat
  axis_data_t exp_data_q[$];
  beat_meta_t exp_meta_q[$];
  int         n_accepted = 0;
  int         bp_start;

  assign in_meta  = {s_axis_tkeep, s_axis_tlast, s_axis_tid, s_axis_tuser};
  assign out_meta = {m_axis_tkeep, m_axis_tlast, m_axis_tid, m_axis_tuser};

  stream_adder_top UUT (.*);

  initial begin
    s_axis_aclk = 1'b0;
    forever #10 s_axis_aclk = ~s_axis_aclk;
  end

  ////////////////////////////////////////
  // Failure reporting and compares
  ////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Finished with errors");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_data(input string name, input axis_data_t exp, input axis_data_t act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      abort_run("Data mismatch on the output stream");
    end
  endtask

  task automatic check_meta(input string name, input beat_meta_t exp, input beat_meta_t act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      abort_run("Sideband mismatch on the output stream");
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      $display("** Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
      abort_run("Control flag mismatch");
    end
  endtask

  ////////////////////////////////////////
  // Model and stimulus helpers
  ////////////////////////////////////////
  // Each 16-bit lane plus the constant, carry dropped
  function automatic axis_data_t add_constant(input axis_data_t d, input lane_t c);
    axis_data_t      sum;
    logic [lane_w:0] wide;
    for (int i = 0; i < num_lanes; i++) begin
      wide = {1'b0, d[i*lane_w +: lane_w]} + {1'b0, c};
      sum[i*lane_w +: lane_w] = wide[lane_w-1:0]; // Modulo 2^16
    end
    return sum;
  endfunction

  function automatic axis_data_t random_data(input bit edge_values);
    axis_data_t d;
    d = {$urandom, $urandom};
    for (int i = 0; i < num_lanes; i++) begin
      if (edge_values && $urandom_range(2) == 0) begin
        d[i*lane_w +: lane_w] = '1; // All-ones lane
      end
    end
    return d;
  endfunction

  function automatic lane_t random_constant(input bit edge_values);
    if (edge_values && $urandom_range(1) == 1) begin
      return lane_t'($urandom_range(16'hffff, 16'hff00)); // Nearly always wraps
    end else begin
      return lane_t'($urandom_range(16'hffff));
    end
  endfunction

  task automatic drive_phase(input int cycles, input int valid_pct, input int ready_pct,
                             input int const_pct, input bit edge_values);
    for (int i = 0; i < cycles; i++) begin
      @(posedge s_axis_aclk);
      s_axis_tvalid <= ($urandom_range(99) < valid_pct);
      s_axis_tdata  <= random_data(edge_values);
      s_axis_tkeep  <= $urandom_range(255);
      s_axis_tlast  <= $urandom_range(1);
      s_axis_tid    <= $urandom_range(15);
      s_axis_tuser  <= $urandom_range(255);
      m_axis_tready <= ($urandom_range(99) < ready_pct);
      if ($urandom_range(99) < const_pct) begin
        ctrl_constant <= random_constant(edge_values);
      end
    end
  endtask

  task automatic stop_input();
    @(posedge s_axis_aclk);
    s_axis_tvalid <= 1'b0;
    m_axis_tready <= 1'b1;
  endtask

  task automatic wait_for_ready(input logic level, input string why);
    int cycles;
    cycles = 0;
    @(negedge s_axis_aclk);
    while (s_axis_tready !== level && cycles < wait_limit) begin
      @(negedge s_axis_aclk);
      cycles++;
    end
    if (s_axis_tready !== level) begin
      abort_run(why);
    end
  endtask

  // Queue empty means every accepted beat came out
  task automatic wait_for_drain(input string why);
    int cycles;
    cycles = 0;
    @(negedge s_axis_aclk);
    while (exp_data_q.size() != 0 && cycles < wait_limit) begin
      @(negedge s_axis_aclk);
      cycles++;
    end
    if (exp_data_q.size() != 0) begin
      abort_run(why);
    end
    check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
  endtask

  ////////////////////////////////////////
  // Monitor, pops before it pushes
  ////////////////////////////////////////
  always @(posedge s_axis_aclk) begin
    if (!rst) begin
      if (m_axis_tvalid && m_axis_tready) begin
        if (exp_data_q.size() == 0) begin
          abort_run("Output beat appeared with no beat expected");
        end else begin
          check_data("m_axis_tdata", exp_data_q.pop_front(), m_axis_tdata);
          check_meta("m_axis_{tkeep,tlast,tid,tuser}", exp_meta_q.pop_front(), out_meta);
        end
      end
      if (s_axis_tvalid && s_axis_tready) begin
        exp_data_q.push_back(add_constant(s_axis_tdata, ctrl_constant));
        exp_meta_q.push_back(in_meta);
        n_accepted++;
      end
    end
  end

  initial begin
    void'($urandom(81));
    rst           = 1'b1;
    ctrl_constant = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdata  = '0;
    s_axis_tkeep  = '0;
    s_axis_tlast  = 1'b0;
    s_axis_tid    = '0;
    s_axis_tuser  = '0;
    m_axis_tready = 1'b0;

    for (int i = 0; i < 4; i++) begin
      @(posedge s_axis_aclk);
      @(negedge s_axis_aclk);
      check_flag("m_axis_tvalid", 1'b0, m_axis_tvalid);
    end
    @(posedge s_axis_aclk);
    rst <= 1'b0;
    wait_for_ready(1'b1, "s_axis_tready never rose after reset");

    drive_phase(300, 80, 90, 10, 1'b1);  // All-ones lanes, wrapping constants
    drive_phase(400, 50, 50, 5, 1'b0);   // Valid gaps and random ready
    drive_phase(400, 70, 70, 100, 1'b1); // New constant every cycle
    stop_input();
    wait_for_drain("Beats stuck in the DUT before the back-pressure phase");

    // Output held off while beats are offered every cycle
    bp_start = n_accepted;
    drive_phase(60, 100, 0, 20, 1'b0);
    wait_for_ready(1'b0, "s_axis_tready never fell under back-pressure");
    @(negedge s_axis_aclk);
    if (n_accepted - bp_start > fifo_depth) begin
      abort_run("More beats accepted under back-pressure than the FIFO holds");
    end
    stop_input();
    wait_for_drain("FIFO did not drain after back-pressure was released");

    drive_phase(300, 60, 60, 30, 1'b1);
    stop_input();
    wait_for_drain("Queue did not drain at the end of the run");
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- logic/stream_adder_top.sv
/*
  AXI4-Stream lane adder top level
  Packs the input sidebands, runs the adder pipeline and the output FIFO
*/
`timescale 1ns/1ns

module stream_adder_top (
  input  logic                                s_axis_aclk,
  input  logic                                rst,
  input  logic [lane_adder_pkg::lane_w-1:0]   ctrl_constant,
  input  logic                                s_axis_tvalid,
  output logic                                s_axis_tready,
  input  logic [lane_adder_pkg::data_w-1:0]   s_axis_tdata,
  input  logic [lane_adder_pkg::data_w/8-1:0] s_axis_tkeep,
  input  logic                                s_axis_tlast,
  input  logic [lane_adder_pkg::id_w-1:0]     s_axis_tid,
  input  logic [lane_adder_pkg::user_w-1:0]   s_axis_tuser,
  output logic                                m_axis_tvalid,
  input  logic                                m_axis_tready,
  output logic [lane_adder_pkg::data_w-1:0]   m_axis_tdata,
  output logic [lane_adder_pkg::data_w/8-1:0] m_axis_tkeep,
  output logic                                m_axis_tlast,
  output logic [lane_adder_pkg::id_w-1:0]     m_axis_tid,
  output logic [lane_adder_pkg::user_w-1:0]   m_axis_tuser
);
  import lane_adder_pkg::*;

  beat_meta_t s_meta;   // Sidebands in
  beat_meta_t m_meta;   // Sidebands out
  logic       wr_ready; // Registered not-prog-full

  axis_beat_if beat_if ();

  assign s_meta.keep = s_axis_tkeep;
  assign s_meta.last = s_axis_tlast;
  assign s_meta.id   = s_axis_tid;
  assign s_meta.user = s_axis_tuser;

  lane_add_pipe u_pipe (
    .s_axis_aclk  (s_axis_aclk),
    .rst          (rst),
    .s_axis_tvalid(s_axis_tvalid),
    .wr_ready     (wr_ready),
    .s_axis_tdata (s_axis_tdata),
    .s_axis_meta  (s_meta),
    .ctrl_constant(ctrl_constant),
    .beat_out     (beat_if)
  );

  axis_sync_fifo #(
    .depth(fifo_depth)
  ) u_fifo (
    .s_axis_aclk  (s_axis_aclk),
    .rst          (rst),
    .beat_in      (beat_if),
    .wr_ready     (wr_ready),
    .m_axis_tvalid(m_axis_tvalid),
    .m_axis_tready(m_axis_tready),
    .m_axis_tdata (m_axis_tdata),
    .m_axis_meta  (m_meta)
  );

  assign s_axis_tready = wr_ready;

  // Unpack sidebands at the output
  assign m_axis_tkeep = m_meta.keep;
  assign m_axis_tlast = m_meta.last;
  assign m_axis_tid   = m_meta.id;
  assign m_axis_tuser = m_meta.user;

endmodule

//--- logic/axis_sync_fifo.sv
/*
  Synchronous show-ahead stream FIFO
  Circular buffer with fill count and programmable-full flag
  Write ready is the registered inverse of programmable full
*/
`timescale 1ns/1ns

module axis_sync_fifo #(
  parameter int depth = lane_adder_pkg::fifo_depth // Power of two
) (
  input  logic                       s_axis_aclk,
  input  logic                       rst,
  axis_beat_if.dst                   beat_in,
  output logic                       wr_ready,
  output logic                       m_axis_tvalid,
  input  logic                       m_axis_tready,
  output lane_adder_pkg::axis_data_t m_axis_tdata,
  output lane_adder_pkg::beat_meta_t m_axis_meta
);
  import lane_adder_pkg::*;

  ////////////////////////////////////////
  // Storage and pointers
  ////////////////////////////////////////
  axis_data_t data_mem [depth];
  beat_meta_t meta_mem [depth];

  logic [$clog2(depth)-1:0]   wr_ptr; // Wraps at depth
  logic [$clog2(depth)-1:0]   rd_ptr;
  logic [$clog2(depth+1)-1:0] count;  // Entries held, 0 to depth

  logic wr_en;
  logic rd_en;
  logic prog_full;

  assign wr_en     = beat_in.valid;                  // Room was reserved upstream
  assign rd_en     = m_axis_tvalid & m_axis_tready;
  assign prog_full = (count >= prog_full_thresh);

  // Memory write
  always_ff @(posedge s_axis_aclk) begin
    if (wr_en) begin
      data_mem[wr_ptr] <= beat_in.data;
      meta_mem[wr_ptr] <= beat_in.meta;
    end
  end

  // Pointers and fill count
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_en) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count; // Both or neither
      endcase
    end
  end

  // Ready lags the flag by one cycle
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      wr_ready <= 1'b0;
    end else begin
      wr_ready <= ~prog_full;
    end
  end

  ////////////////////////////////////////
  // Show-ahead read port
  ////////////////////////////////////////
  assign m_axis_tvalid = (count != '0);
  assign m_axis_tdata  = data_mem[rd_ptr];
  assign m_axis_meta   = meta_mem[rd_ptr];

  // The threshold margin must keep in-flight beats from overrunning
  a_no_write_when_full: assert property (
    @(posedge s_axis_aclk) disable iff (rst)
    wr_en |-> (count < depth)
  ) else $error("write into a full FIFO");

  // Stalled head beat stays put until it is taken
  a_hold_until_taken: assert property (
    @(posedge s_axis_aclk) disable iff (rst)
    (m_axis_tvalid && !m_axis_tready) |=>
      (m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_meta))
  ) else $error("output beat changed before it was taken");

endmodule

//--- logic/lane_add_pipe.sv
/*
  Two-stage lane adder pipeline
  Stage 1 registers the beat, its ready and the constant
  Stage 2 adds the constant to every lane, modulo 2^16
*/
`timescale 1ns/1ns

module lane_add_pipe (
  input  logic                       s_axis_aclk,
  input  logic                       rst,
  input  logic                       s_axis_tvalid,
  input  logic                       wr_ready,
  input  lane_adder_pkg::axis_data_t s_axis_tdata,
  input  lane_adder_pkg::beat_meta_t s_axis_meta,
  input  lane_adder_pkg::lane_t      ctrl_constant,
  axis_beat_if.src                   beat_out
);
  import lane_adder_pkg::*;

  ////////////////////////////////////////
  // Stage 1 registers
  ////////////////////////////////////////
  logic       s1_valid;
  logic       s1_ready; // Ready as seen at the sampling edge
  axis_data_t s1_data;
  beat_meta_t s1_meta;
  lane_t      s1_constant;

  ////////////////////////////////////////
  // Stage 2 registers
  ////////////////////////////////////////
  logic       s2_valid;
  axis_data_t s2_data;
  beat_meta_t s2_meta;

  // Stage 1 control
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s1_ready <= 1'b0;
    end else begin
      s1_valid <= s_axis_tvalid;
      s1_ready <= wr_ready;
    end
  end

  // Stage 1 payload, constant sampled with its beat
  always_ff @(posedge s_axis_aclk) begin
    s1_data     <= s_axis_tdata;
    s1_meta     <= s_axis_meta;
    s1_constant <= ctrl_constant;
  end

  // Only beats that were really accepted move on
  always_ff @(posedge s_axis_aclk) begin
    if (rst) begin
      s2_valid <= 1'b0;
    end else begin
      s2_valid <= s1_valid & s1_ready;
    end
  end

  // Lane adders, carry out of each lane is dropped
  always_ff @(posedge s_axis_aclk) begin
    for (int i = 0; i < num_lanes; i++) begin
      s2_data[i*lane_w +: lane_w] <= s1_data[i*lane_w +: lane_w] + s1_constant;
    end
    s2_meta <= s1_meta;
  end

  assign beat_out.valid = s2_valid;
  assign beat_out.data  = s2_data;
  assign beat_out.meta  = s2_meta;

endmodule

//--- logic/axis_beat_if.sv
/*
  One stream beat between the adder pipeline and the output FIFO
  Valid, data and sideband metadata; no ready, writes are never refused
*/
`timescale 1ns/1ns

interface axis_beat_if;
  import lane_adder_pkg::*;

  logic       valid; // Beat is written this cycle
  axis_data_t data;
  beat_meta_t meta;  // keep, last, id, user

  // Pipeline side
  modport src (
    output valid,
    output data,
    output meta
  );

  // FIFO side
  modport dst (
    input valid,
    input data,
    input meta
  );

endinterface

//--- logic/lane_adder_pkg.sv
/*
  Widths, lane count and FIFO sizing for the stream lane adder
  Data, lane and sideband metadata types shared by the pipeline and FIFO
*/
package lane_adder_pkg;

  ////////////////////////////////////////
  // Stream widths
  ////////////////////////////////////////
  localparam int data_w    = 64;              // tdata bits
  localparam int lane_w    = 16;              // One adder lane and the constant
  localparam int num_lanes = data_w / lane_w; // Lanes per beat
  localparam int id_w      = 4;               // tid bits
  localparam int user_w    = 8;               // tuser bits

  ////////////////////////////////////////
  // FIFO sizing
  ////////////////////////////////////////
  localparam int fifo_depth = 32;

  // Spare room of 5 entries covers two pipeline stages
  // plus the cycle that ready takes to fall
  localparam int prog_full_thresh = fifo_depth - 5;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////
  typedef logic [data_w-1:0] axis_data_t;
  typedef logic [lane_w-1:0] lane_t;

  // Sidebands that ride along with each beat unchanged
  typedef struct packed {
    logic [data_w/8-1:0] keep;
    logic                last;
    logic [id_w-1:0]     id;
    logic [user_w-1:0]   user;
  } beat_meta_t;

endpackage
